//--- tb.f
hdl/pkt_mux_pkg.sv
hdl/pkt_admit.sv
hdl/pkt_fifo.sv
hdl/pkt_mux_ctrl.sv
hdl/pkt_egress.sv
hdl/pkt_mux.sv
verification/tb_pkt_mux.sv

//--- Makefile
# Verilator build and run of the packet multiplexer testbench

VERILATOR ?= verilator
TOP       ?= tb_pkt_mux
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= >>> PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

//--- verification/tb_pkt_mux.sv
//##########################################################################
// Testbench for the packet multiplexer. Sends LFSR-shaped DMA and DRA
// traffic, models admission per source and checks the output stream with
// concurrent assertions against per-source queues of expected beats.
//##########################################################################

`timescale 1ns/1ns

module tb_pkt_mux;

  import pkt_mux_pkg::*;

  localparam int TIMEOUT = 5000;  // cycles per wait loop

  logic              i_clk;
  logic              i_rst_n;
  logic              i_dma_valid;
  logic [BEAT_W-1:0] i_dma_beat;
  logic              i_dra_valid;
  logic [BEAT_W-1:0] i_dra_beat;
  logic              i_alf;
  logic              o_data_valid;
  logic [BEAT_W-1:0] o_data;
  logic              o_meta_valid;
  logic [META_W-1:0] o_meta;

  logic [31:0]       lfsr;
  int                errors;
  int                timeouts;
  int                beats_out;
  int                dropped;
  int                alf_run;
  int                fill [2];          // modeled fill, 0 DMA and 1 DRA
  int                seq [2];
  bit                traffic_on;
  bit                in_pkt;            // output stream is inside a packet
  bit                cur_src;
  logic [BEAT_W-1:0] beat_q [2][$];     // expected output beats
  logic [META_W-1:0] meta_q [2][$];
  bit                exp_have;
  bit                exp_mv;
  logic [BEAT_W-1:0] exp_beat;
  logic [META_W-1:0] exp_meta;

  pkt_mux u_dut (.*);

  always #2 i_clk = ~i_clk;

  // 32-bit Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int          k;
    r = '0;
    for (k = 0; k < n; k++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic flag_error(input string msg);
    errors++;
    $display("Error %0t: %s", $time, msg);
  endtask

  task automatic drive_beat(input bit dra, input bit valid, input logic [BEAT_W-1:0] beat);
    @(posedge i_clk);
    #1;
    if (dra) begin
      i_dra_valid = valid;
      i_dra_beat  = beat;
    end else begin
      i_dma_valid = valid;
      i_dma_beat  = beat;
    end
  endtask

  task automatic send_packet(input bit dra, input int gap_max, input bit wait_room);
    int                len;
    int                cycles;
    int                i;
    bit                admit;
    pkt_body_u         m1;
    pkt_body_u         m2;
    logic [BEAT_W-1:0] beat;
    logic [TAG_W-1:0]  tag;
    logic [3:0]        id;
    len    = 4 + rand_bits(5) % (MAX_PKT_BEATS - 3);
    id     = dra ? 4'h5 : 4'ha;
    cycles = 0;
    while (wait_room && (fill[dra] >= ADMIT_LIMIT) && (cycles < TIMEOUT)) begin
      @(posedge i_clk);
      cycles++;
    end
    if (cycles == TIMEOUT) begin
      timeouts++;
      $display("timeout: %s buffer never drained below the admission limit",
               dra ? "DRA" : "DMA");
      return;
    end
    admit  = (fill[dra] < ADMIT_LIMIT);
    m1.raw = {28'hdeadbee, id, 16'(seq[dra]), 8'(len), 44'h0, rand_bits(32)};
    m2.raw = {{17{4'hc}}, rand_bits(32), rand_bits(32)};  // high bits never leave
    if (admit) begin
      fill[dra] += len;
      meta_q[dra].push_back({m1.raw[META_HI_W-1:0], m2.raw[META_LO_W-1:0]});
    end else begin
      dropped++;
    end
    for (i = 0; i < len; i++) begin
      tag = (i == len - 1) ? TAG_TAIL : ((dra && i == 2) ? TAG_HEAD : TAG_MID);
      case (i)
        0:       beat = {dra ? TAG_DRA_START : TAG_HEAD, m1.raw};
        1:       beat = {TAG_MID, m2.raw};
        default: beat = {tag, id, 16'(seq[dra]), 8'(i), {13{8'(i * 37 + seq[dra])}}};
      endcase
      if (admit && i >= 2) begin
        // DMA data head leaves retagged as head
        beat_q[dra].push_back((!dra && i == 2) ? {TAG_HEAD, beat[BODY_W-1:0]} : beat);
      end
      repeat (rand_bits(2) % (gap_max + 1)) drive_beat(dra, 1'b0, beat);
      drive_beat(dra, 1'b1, beat);
    end
    seq[dra]++;
    repeat (1 + rand_bits(2)) drive_beat(dra, 1'b0, beat);  // tail written before next start
  endtask

  task automatic wait_drained;
    int cycles;
    cycles = 0;
    while ((beat_q[0].size() + beat_q[1].size() != 0) && (cycles < TIMEOUT)) begin
      @(posedge i_clk);
      cycles++;
    end
    if (cycles == TIMEOUT) begin
      timeouts++;
      $display("timeout: expected packets never left the multiplexer");
    end
  endtask

  task automatic run_traffic(input int n_pkts);
    traffic_on = 1'b1;
    fork
      repeat (n_pkts) send_packet(1'b0, 2, 1'b1);
      repeat (n_pkts) send_packet(1'b1, 2, 1'b1);
    join
    wait_drained();
    traffic_on = 1'b0;
    @(posedge i_clk);
    #1;
    i_alf = 1'b0;
  endtask

  // almost-full comes in short runs
  always @(posedge i_clk) begin
    if (traffic_on) begin
      if (alf_run > 0) begin
        alf_run--;
      end else if (rand_bits(3) == 0) begin
        alf_run = 1 + rand_bits(3);
      end
      #1;
      i_alf = (alf_run > 0);
    end
  end

  // expected value for the beat on the outputs, then consume it
  always @(negedge i_clk) begin : monitor
    bit src;
    src      = in_pkt ? cur_src : (o_meta[META_W-1 -: 4] == 4'h5);
    exp_have = 1'b0;
    if ((beat_q[src].size() != 0) && (meta_q[src].size() != 0)) begin
      exp_have = 1'b1;
      exp_beat = beat_q[src][0];
      exp_meta = meta_q[src][0];
      exp_mv   = src ? (exp_beat[BEAT_W-1 -: TAG_W] == TAG_HEAD) : !in_pkt;
    end
    if (i_rst_n && o_data_valid && exp_have) begin
      beats_out++;
      fill[src] -= in_pkt ? 1 : 3;  // meta beats were read before the head
      in_pkt  = (exp_beat[BEAT_W-1 -: TAG_W] != TAG_TAIL);
      cur_src = src;
      void'(beat_q[src].pop_front());
      if (!in_pkt) begin
        void'(meta_q[src].pop_front());
      end
    end
  end

  a_reset_quiet : assert property (@(posedge i_clk)
    (!i_rst_n || $past(!i_rst_n)) |-> (!o_data_valid && !o_meta_valid))
    else flag_error("output valid during or right after reset");

  a_beat_match : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_data_valid |-> (exp_have && (o_data == exp_beat)))
    else flag_error("output beat differs from the expected packet beat");

  a_meta_flag : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_data_valid |-> (o_meta_valid == exp_mv))
    else flag_error("o_meta_valid wrong for this output beat");

  a_meta_word : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_meta_valid |-> (o_data_valid && exp_have && (o_meta == exp_meta)))
    else flag_error("o_meta differs from the packet metadata");

  // two beats may still be in flight when almost-full rises
  a_alf_limit : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_alf && $past(i_alf) && $past(i_alf, 2)) |=> !o_data_valid)
    else flag_error("beat sent after almost-full stayed high");

  initial begin
    i_clk       = 1'b0;
    i_rst_n     = 1'b0;
    i_dma_valid = 1'b0;
    i_dma_beat  = '0;
    i_dra_valid = 1'b0;
    i_dra_beat  = '0;
    i_alf       = 1'b0;
    lfsr        = 32'h94e;
    errors      = 0;
    timeouts    = 0;
    beats_out   = 0;
    dropped     = 0;
    alf_run     = 0;
    fill        = '{0, 0};
    seq         = '{0, 0};
    traffic_on  = 1'b0;
    in_pkt      = 1'b0;
    cur_src     = 1'b0;
    exp_have    = 1'b0;
    repeat (5) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;
    run_traffic(12);
    // burst into stalled buffers, later starts are dropped
    i_alf = 1'b1;
    repeat (4) @(posedge i_clk);
    fork
      repeat (8) send_packet(1'b0, 1, 1'b0);
      repeat (8) send_packet(1'b1, 1, 1'b0);
    join
    repeat (4) @(posedge i_clk);
    #1;
    i_alf = 1'b0;
    run_traffic(6);
    repeat (20) @(posedge i_clk);  // room for stray beats
    $display("tb_pkt_mux: %0d beats checked, %0d packets dropped, %0d errors, %0d timeouts",
             beats_out, dropped, errors, timeouts);
    if ((errors == 0) && (timeouts == 0)) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- hdl/pkt_mux.sv
//##########################################################################
// Two-source packet multiplexer top. DMA and DRA beats pass admission into
// their own buffers; the controller drains one packet at a time to egress.
//##########################################################################

`timescale 1ns/1ns

module pkt_mux (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_dma_valid,
  input  logic [pkt_mux_pkg::BEAT_W-1:0] i_dma_beat,
  input  logic                           i_dra_valid,
  input  logic [pkt_mux_pkg::BEAT_W-1:0] i_dra_beat,
  input  logic                           i_alf,         // sink almost full
  output logic                           o_data_valid,
  output logic [pkt_mux_pkg::BEAT_W-1:0] o_data,
  output logic                           o_meta_valid,
  output logic [pkt_mux_pkg::META_W-1:0] o_meta
);

  import pkt_mux_pkg::*;

  logic              dma_wr_en;
  logic [BEAT_W-1:0] dma_wr_beat;
  logic [CNT_W-1:0]  dma_count;
  logic              dma_pkt_ready;
  logic              dma_rd_en;
  logic [BEAT_W-1:0] dma_rd_beat;

  logic              dra_wr_en;
  logic [BEAT_W-1:0] dra_wr_beat;
  logic [CNT_W-1:0]  dra_count;
  logic              dra_pkt_ready;
  logic              dra_rd_en;
  logic [BEAT_W-1:0] dra_rd_beat;

  logic              sel_dra;
  logic [1:0]        phase;
  logic              rd_active;

  pkt_admit #(.START_TAG(TAG_HEAD)) u_dma_admit (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_valid   (i_dma_valid),
    .i_beat    (i_dma_beat),
    .i_count   (dma_count),
    .o_wr_en   (dma_wr_en),
    .o_wr_beat (dma_wr_beat)
  );

  pkt_admit #(.START_TAG(TAG_DRA_START)) u_dra_admit (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_valid   (i_dra_valid),
    .i_beat    (i_dra_beat),
    .i_count   (dra_count),
    .o_wr_en   (dra_wr_en),
    .o_wr_beat (dra_wr_beat)
  );

  pkt_fifo u_dma_fifo (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_wr_en     (dma_wr_en),
    .i_wr_beat   (dma_wr_beat),
    .i_rd_en     (dma_rd_en),
    .o_rd_beat   (dma_rd_beat),
    .o_count     (dma_count),
    .o_pkt_ready (dma_pkt_ready)
  );

  pkt_fifo u_dra_fifo (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_wr_en     (dra_wr_en),
    .i_wr_beat   (dra_wr_beat),
    .i_rd_en     (dra_rd_en),
    .o_rd_beat   (dra_rd_beat),
    .o_count     (dra_count),
    .o_pkt_ready (dra_pkt_ready)
  );

  pkt_mux_ctrl u_ctrl (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_alf       (i_alf),
    .i_dra_valid (i_dra_valid),
    .i_dma_ready (dma_pkt_ready),
    .i_dra_ready (dra_pkt_ready),
    .i_dma_tag   (dma_rd_beat[BEAT_W-1 -: TAG_W]),
    .i_dra_tag   (dra_rd_beat[BEAT_W-1 -: TAG_W]),
    .o_dma_rd_en (dma_rd_en),
    .o_dra_rd_en (dra_rd_en),
    .o_sel_dra   (sel_dra),
    .o_phase     (phase),
    .o_rd_active (rd_active)
  );

  pkt_egress u_egress (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_dma_beat   (dma_rd_beat),
    .i_dra_beat   (dra_rd_beat),
    .i_sel_dra    (sel_dra),
    .i_phase      (phase),
    .i_rd_active  (rd_active),
    .o_data_valid (o_data_valid),
    .o_data       (o_data),
    .o_meta_valid (o_meta_valid),
    .o_meta       (o_meta)
  );

endmodule

//--- hdl/pkt_egress.sv
//##########################################################################
// Output stage. Collects the two metadata beats into the 168-bit metadata
// word, retags the DMA data head and registers beat and metadata outputs.
//##########################################################################

`timescale 1ns/1ns

module pkt_egress (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic [pkt_mux_pkg::BEAT_W-1:0] i_dma_beat,
  input  logic [pkt_mux_pkg::BEAT_W-1:0] i_dra_beat,
  input  logic                           i_sel_dra,
  input  logic [1:0]                     i_phase,
  input  logic                           i_rd_active,
  output logic                           o_data_valid,
  output logic [pkt_mux_pkg::BEAT_W-1:0] o_data,
  output logic                           o_meta_valid,
  output logic [pkt_mux_pkg::META_W-1:0] o_meta
);

  import pkt_mux_pkg::*;

  logic [BEAT_W-1:0] beat;
  logic [TAG_W-1:0]  tag;
  pkt_body_u         body;
  logic              data_phase;
  logic              dma_head;

  assign beat       = i_sel_dra ? i_dra_beat : i_dma_beat;
  assign tag        = beat[BEAT_W-1 -: TAG_W];
  assign body       = beat[BODY_W-1:0];
  assign data_phase = i_rd_active && ((i_phase == PH_HEAD) || (i_phase == PH_BODY));
  assign dma_head   = !i_sel_dra && (i_phase == PH_HEAD);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_data_valid <= 1'b0;
      o_meta_valid <= 1'b0;
    end else begin
      o_data_valid <= data_phase;  // meta beats are consumed here
      // DRA marks its heads itself, DMA head is the third beat
      o_meta_valid <= data_phase && (i_sel_dra ? (tag == TAG_HEAD) : dma_head);
    end
  end

  always_ff @(posedge i_clk) begin
    if (data_phase) begin
      o_data <= dma_head ? {TAG_HEAD, body.raw} : beat;
    end
    if (i_rd_active && (i_phase == PH_META_HI)) begin
      o_meta[META_W-1 -: META_HI_W] <= body.meta[META_HI_W/NIB_W-1:0];
    end
    if (i_rd_active && (i_phase == PH_META_LO)) begin
      o_meta[META_LO_W-1:0] <= body.meta[META_LO_W/NIB_W-1:0];
    end
  end

endmodule

//--- hdl/pkt_mux_ctrl.sv
//##########################################################################
// Read controller. Picks DMA or DRA, reads one whole packet back to back,
// pauses a cycle after every almost-full cycle and stops on the tail beat.
//##########################################################################

`timescale 1ns/1ns

module pkt_mux_ctrl (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  input  logic                          i_alf,
  input  logic                          i_dra_valid,
  input  logic                          i_dma_ready,
  input  logic                          i_dra_ready,
  input  logic [pkt_mux_pkg::TAG_W-1:0] i_dma_tag,    // tag at FIFO output
  input  logic [pkt_mux_pkg::TAG_W-1:0] i_dra_tag,
  output logic                          o_dma_rd_en,
  output logic                          o_dra_rd_en,
  output logic                          o_sel_dra,
  output logic [1:0]                    o_phase,      // phase of FIFO output
  output logic                          o_rd_active   // FIFO output is a read beat
);

  import pkt_mux_pkg::*;

  logic             busy;       // a packet is being read
  logic [1:0]       rd_phase;   // phase of the next read
  logic             alf_q;
  logic             rd_en;
  logic             tail_seen;
  logic [TAG_W-1:0] cur_tag;
  logic             start_dma;
  logic             start_dra;

  assign cur_tag   = o_sel_dra ? i_dra_tag : i_dma_tag;
  assign tail_seen = o_rd_active && (cur_tag == TAG_TAIL);

  // the read that is in flight may be the tail, so nothing more is read
  // in the cycle where the tail shows up
  assign rd_en       = busy && !alf_q && !tail_seen;
  assign o_dma_rd_en = rd_en && !o_sel_dra;
  assign o_dra_rd_en = rd_en && o_sel_dra;

  // DMA goes first unless DRA is arriving right now
  assign start_dma = !i_alf && i_dma_ready && !i_dra_valid;
  assign start_dra = !i_alf && i_dra_ready && !start_dma;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy        <= 1'b0;
      rd_phase    <= PH_META_HI;
      o_sel_dra   <= 1'b0;
      alf_q       <= 1'b0;
      o_rd_active <= 1'b0;
      o_phase     <= PH_META_HI;
    end else begin
      alf_q       <= i_alf;
      o_rd_active <= rd_en;
      o_phase     <= rd_phase;  // follows the beat to the FIFO output
      if (!busy) begin
        if (start_dma || start_dra) begin
          busy      <= 1'b1;
          o_sel_dra <= start_dra;
          rd_phase  <= PH_META_HI;
        end
      end else if (tail_seen) begin
        busy <= 1'b0;
      end else if (rd_en && (rd_phase != PH_BODY)) begin
        rd_phase <= rd_phase + 2'd1;  // meta hi -> meta lo -> head -> body
      end
    end
  end

  // one packet at a time, so at most one buffer is drained per cycle
  a_one_rd_en : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(o_dma_rd_en && o_dra_rd_en))
    else $error("both packet FIFOs read in the same cycle");

endmodule

//--- hdl/pkt_fifo.sv
//##########################################################################
// Synchronous beat buffer with registered read port. Reports its fill for
// admission and whether a complete packet is stored for the controller.
//##########################################################################

`timescale 1ns/1ns

module pkt_fifo (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_wr_en,
  input  logic [pkt_mux_pkg::BEAT_W-1:0] i_wr_beat,
  input  logic                           i_rd_en,
  output logic [pkt_mux_pkg::BEAT_W-1:0] o_rd_beat,
  output logic [pkt_mux_pkg::CNT_W-1:0]  o_count,
  output logic                           o_pkt_ready
);

  import pkt_mux_pkg::*;

  logic [BEAT_W-1:0]  mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [CNT_W-1:0]   pkt_cnt;
  logic               rd_vld_q;
  logic               wr_tail;
  logic               rd_tail;

  assign wr_tail     = i_wr_en && (i_wr_beat[BEAT_W-1 -: TAG_W] == TAG_TAIL);
  assign rd_tail     = rd_vld_q && (o_rd_beat[BEAT_W-1 -: TAG_W] == TAG_TAIL);
  assign o_pkt_ready = (pkt_cnt != '0);

  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      mem[wr_ptr] <= i_wr_beat;
    end
    if (i_rd_en) begin
      o_rd_beat <= mem[rd_ptr];  // valid the cycle after rd_en
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      o_count  <= '0;
      pkt_cnt  <= '0;
      rd_vld_q <= 1'b0;
    end else begin
      if (i_wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      end
      if (i_rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      o_count  <= o_count + CNT_W'(i_wr_en) - CNT_W'(i_rd_en);
      pkt_cnt  <= pkt_cnt + CNT_W'(wr_tail) - CNT_W'(rd_tail);  // tail seen on out
      rd_vld_q <= i_rd_en;
    end
  end

  // admission margin must keep writes off a full buffer
  a_no_wr_full : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_wr_en |-> (o_count < CNT_W'(FIFO_DEPTH)))
    else $error("write into full packet FIFO");

  // controller must only read stored beats of a ready packet
  a_no_rd_empty : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_rd_en |-> (o_count != '0))
    else $error("read from empty packet FIFO");

endmodule

//--- hdl/pkt_admit.sv
//##########################################################################
// Per-source admission stage. Decides on each start beat whether the whole
// packet fits below the admission limit and forwards or drops it.
//##########################################################################

`timescale 1ns/1ns

module pkt_admit #(
  parameter logic [pkt_mux_pkg::TAG_W-1:0] START_TAG = pkt_mux_pkg::TAG_HEAD
) (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_valid,
  input  logic [pkt_mux_pkg::BEAT_W-1:0] i_beat,
  input  logic [pkt_mux_pkg::CNT_W-1:0]  i_count,    // fill of own FIFO
  output logic                           o_wr_en,
  output logic [pkt_mux_pkg::BEAT_W-1:0] o_wr_beat
);

  import pkt_mux_pkg::*;

  logic [1:0]       state;
  logic [TAG_W-1:0] tag;
  logic             room;

  assign tag  = i_beat[BEAT_W-1 -: TAG_W];
  assign room = (i_count < CNT_W'(ADMIT_LIMIT));

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state   <= ADM_IDLE;
      o_wr_en <= 1'b0;
    end else begin
      o_wr_en <= 1'b0;
      case (state)
        ADM_IDLE: begin
          // stray beats between packets are dropped here
          if (i_valid && (tag == START_TAG)) begin
            if (room) begin
              state   <= ADM_PASS;
              o_wr_en <= 1'b1;
            end else begin
              state   <= ADM_DISCARD;  // no room, drop whole packet
            end
          end
        end
        ADM_PASS: begin
          if (i_valid) begin
            o_wr_en <= 1'b1;
            if (tag == TAG_TAIL) begin
              state <= ADM_IDLE;
            end
          end
        end
        ADM_DISCARD: begin
          if (i_valid && (tag == TAG_TAIL)) begin
            state <= ADM_IDLE;
          end
        end
        default: begin
          state <= ADM_IDLE;
        end
      endcase
    end
  end

  // beat follows its write enable by the same one cycle
  always_ff @(posedge i_clk) begin
    o_wr_beat <= i_beat;
  end

endmodule

//--- hdl/pkt_mux_pkg.sv
//##########################################################################
// Shared widths, tag codes, buffer limits and the beat-body union of the
// two-source packet multiplexer. Imported by every RTL module and the tb.
//##########################################################################

package pkt_mux_pkg;

  // beat layout: {tag, body}
  localparam int BEAT_W    = 134;
  localparam int TAG_W     = 2;
  localparam int BODY_W    = 132;
  localparam int NIB_W     = 4;   // metadata view is cut in nibbles

  // output metadata: first meta beat over second meta beat
  localparam int META_W    = 168;
  localparam int META_HI_W = 104;
  localparam int META_LO_W = 64;

  // position tags
  localparam logic [TAG_W-1:0] TAG_MID       = 2'b00;
  localparam logic [TAG_W-1:0] TAG_HEAD      = 2'b01;
  localparam logic [TAG_W-1:0] TAG_TAIL      = 2'b10;
  localparam logic [TAG_W-1:0] TAG_DRA_START = 2'b11;

  // per-source buffer
  localparam int FIFO_DEPTH    = 64;
  localparam int FIFO_AW       = 6;
  localparam int CNT_W         = 7;   // holds 0..FIFO_DEPTH

  // ADMIT_LIMIT + MAX_PKT_BEATS must stay within FIFO_DEPTH,
  // otherwise an admitted packet could overrun its buffer
  localparam int ADMIT_LIMIT   = 40;
  localparam int MAX_PKT_BEATS = 24;

  // admission states
  localparam logic [1:0] ADM_IDLE    = 2'd0;
  localparam logic [1:0] ADM_PASS    = 2'd1;
  localparam logic [1:0] ADM_DISCARD = 2'd2;

  // packet phase of a read beat, in read order
  localparam logic [1:0] PH_META_HI = 2'd0;
  localparam logic [1:0] PH_META_LO = 2'd1;
  localparam logic [1:0] PH_HEAD    = 2'd2;
  localparam logic [1:0] PH_BODY    = 2'd3;

  // body of one beat, seen as payload or as metadata nibbles
  typedef union packed {
    logic [BODY_W-1:0]                  raw;   // payload word
    logic [BODY_W/NIB_W-1:0][NIB_W-1:0] meta;  // low nibbles carry metadata
  } pkt_body_u;

endpackage
